// File: include/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry
`define DC_WAYS        2
`define DC_SETS        64
`define DC_LINE_WORDS  4
`define DC_ADDR_W      32

// address split
`define DC_OFS_W  ($clog2(`DC_LINE_WORDS) + 2)
`define DC_IDX_W  ($clog2(`DC_SETS))
`define DC_TAG_W  (`DC_ADDR_W - `DC_IDX_W - `DC_OFS_W)

`endif

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f verilog.f \
    --Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1

// File: src/dcache_align.sv
`timescale 1ns/1ns

module dcache_align (
    input  dcache_pkg::dc_req_t  req,
    input  dcache_pkg::dc_line_t line,
    output logic [31:0]          ld_data,
    output logic [31:0]          st_word,
    output logic                 misaligned
);
    import dcache_pkg::*;

    logic [31:0] word;
    logic [31:0] shifted;
    logic [31:0] mask;
    logic [4:0]  sh;

    assign word    = line[req.addr.f.word];
    assign sh      = {req.addr.f.byte_sel, 3'b000};
    assign shifted = word >> sh;

    always_comb begin
        case (req.size)
            DC_BYTE: begin
                ld_data = {{24{req.sign_ext & shifted[7]}}, shifted[7:0]};
                mask    = 32'h0000_00ff << sh;
            end
            DC_HALF: begin
                ld_data = {{16{req.sign_ext & shifted[15]}}, shifted[15:0]};
                mask    = 32'h0000_ffff << sh;
            end
            default: begin
                ld_data = word;
                mask    = 32'hffff_ffff;
            end
        endcase
    end

    // store bytes land on top of the old word
    assign st_word = (word & ~mask) | ((req.wdata << sh) & mask);

    always_comb begin
        case (req.size)
            DC_BYTE: misaligned = 1'b0;
            DC_HALF: misaligned = req.addr.raw[0];
            default: misaligned = |req.addr.raw[1:0];
        endcase
    end

endmodule

// File: src/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  dcache_pkg::dc_req_t       req,
    input  logic                      req_valid,
    output logic                      req_ready,
    output dcache_pkg::dc_req_t       req_buf,
    output dcache_pkg::dc_resp_t      resp,
    output logic                      resp_valid,
    input  logic                      hit,
    input  logic                      hit_way,
    input  logic                      victim_way,
    input  logic                      victim_dirty,
    input  logic [`DC_TAG_W-1:0]      victim_tag,
    output logic [`DC_IDX_W-1:0]      tag_idx,
    output logic                      tag_we,
    output logic                      tag_way,
    output logic                      tag_dirty_set,
    output logic                      lru_touch,
    output logic [`DC_IDX_W-1:0]      data_idx,
    output logic                      data_we,
    output logic                      data_way,
    output logic [`DC_LINE_WORDS-1:0] data_wstrb,
    output dcache_pkg::dc_line_t      data_wline,
    input  dcache_pkg::dc_line_t      line_rdata,
    input  logic [31:0]               ld_data,
    input  logic [31:0]               st_word,
    input  logic                      misaligned,
    output logic                      mp_start,
    output dcache_pkg::dc_mem_req_t   mp_cmd,
    output dcache_pkg::dc_line_t      mp_wline,
    input  dcache_pkg::dc_line_t      mp_rline,
    input  logic                      mp_done
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB,
        S_REFILL,
        S_REPLAY
    } state_e;

    state_e               state;
    state_e               state_d;
    dc_req_t              req_q;
    logic [1:0]           lk_cnt;
    logic                 vway_q;
    logic [`DC_TAG_W-1:0] vtag_q;
    logic                 start_q;
    logic                 decide;
    logic                 st_hit;
    logic                 fill;

    // compare result is ready two edges into the lookup
    assign decide = (state == S_LOOKUP) && (lk_cnt == 2'd2);
    assign st_hit = decide && hit && req_q.write && !misaligned;
    assign fill   = (state == S_REFILL) && mp_done;

    always_comb begin
        state_d = state;
        case (state)
            S_IDLE:   if (req_valid) state_d = S_LOOKUP;
            S_LOOKUP: begin
                if (decide) begin
                    if (misaligned || hit) begin
                        state_d = S_IDLE;
                    end else if (victim_dirty) begin
                        state_d = S_WB;
                    end else begin
                        state_d = S_REFILL;
                    end
                end
            end
            S_WB:     if (mp_done) state_d = S_REFILL;
            S_REFILL: if (mp_done) state_d = S_REPLAY;
            default:  state_d = S_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            req_q   <= '0;
            lk_cnt  <= '0;
            start_q <= 1'b0;
        end else begin
            state   <= state_d;
            start_q <= (state_d != state) && (state_d == S_WB || state_d == S_REFILL);
            if (state == S_IDLE && req_valid) begin
                req_q <= req;
            end
            if (state == S_LOOKUP && !decide) begin
                lk_cnt <= lk_cnt + 2'd1;
            end else begin
                lk_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decide) begin
            vway_q <= victim_way;
            vtag_q <= victim_tag;
        end
    end

    assign req_ready       = (state == S_IDLE);
    assign req_buf         = req_q;
    assign resp_valid      = decide && (misaligned || hit);
    assign resp.rdata      = ld_data;
    assign resp.misaligned = misaligned;

    assign tag_idx       = req_q.addr.f.index;
    assign tag_we        = st_hit || fill;
    assign tag_way       = fill ? vway_q : hit_way;
    assign tag_dirty_set = st_hit;
    assign lru_touch     = decide && hit && !misaligned;

    assign data_idx   = req_q.addr.f.index;
    assign data_we    = st_hit || fill;
    assign data_way   = (state == S_LOOKUP) ? (hit ? hit_way : victim_way) : vway_q;
    assign data_wstrb = fill ? {`DC_LINE_WORDS{1'b1}} : `DC_LINE_WORDS'(1) << req_q.addr.f.word;
    assign data_wline = fill ? mp_rline : {`DC_LINE_WORDS{st_word}};

    // writeback goes to the victim's own line address
    assign mp_start        = start_q;
    assign mp_cmd.write    = (state == S_WB);
    assign mp_cmd.line_addr = (state == S_WB) ?
        {vtag_q, req_q.addr.f.index, {`DC_OFS_W{1'b0}}} :
        {req_q.addr.raw[`DC_ADDR_W-1:`DC_OFS_W], {`DC_OFS_W{1'b0}}};
    assign mp_wline        = line_rdata;

    a_resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid);

    // a start follows a miss decision or a finished writeback
    a_start_on_entry: assert property (@(posedge clk) disable iff (rst)
        mp_start |-> (state == S_WB || state == S_REFILL) &&
                     ($past(decide) || $past(mp_done)));

endmodule

// File: src/dcache_data_array.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_data_array (
    input  logic                     clk,
    input  logic [`DC_IDX_W-1:0]     rd_idx,
    input  logic                     rd_way,
    output dcache_pkg::dc_line_t     rdata,
    input  logic [`DC_IDX_W-1:0]     wr_idx,
    input  logic                     we,
    input  logic                     wr_way,
    input  logic [`DC_LINE_WORDS-1:0] wstrb,
    input  dcache_pkg::dc_line_t     wline
);
    import dcache_pkg::*;

    dc_line_t mem_q [`DC_WAYS][`DC_SETS];
    dc_line_t rd_q [`DC_WAYS];

    // both ways are read, the way is picked after the compare
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            rd_q[w] <= mem_q[w][rd_idx];
        end
        if (we) begin
            for (int i = 0; i < `DC_LINE_WORDS; i++) begin
                if (wstrb[i]) begin
                    mem_q[wr_way][wr_idx][i] <= wline[i];
                end
            end
        end
    end

    assign rdata = rd_q[rd_way];

endmodule

// File: src/dcache_mem_port.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_mem_port (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  dcache_pkg::dc_mem_req_t cmd,
    input  dcache_pkg::dc_line_t    wline,
    output dcache_pkg::dc_line_t    rline,
    output logic                    done,
    output dcache_pkg::dc_mem_req_t mem_req,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output logic [31:0]             mem_wdata,
    output logic                    mem_wvalid,
    input  logic                    mem_wready,
    input  logic [31:0]             mem_rdata,
    input  logic                    mem_rvalid,
    input  logic                    mem_rlast
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        P_IDLE,
        P_CMD,
        P_WR,
        P_RD
    } pstate_e;

    pstate_e                          state;
    logic [$clog2(`DC_LINE_WORDS)-1:0] cnt;
    dc_mem_req_t                      cmd_q;
    dc_line_t                         wline_q;
    dc_line_t                         rline_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= P_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (start) begin
                        state <= P_CMD;
                    end
                end
                P_CMD: begin
                    if (mem_req_ready) begin
                        state <= cmd_q.write ? P_WR : P_RD;
                        cnt   <= '0;
                    end
                end
                P_WR: begin
                    if (mem_wready) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == `DC_LINE_WORDS - 1) begin
                            state <= P_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (mem_rvalid) begin
                        cnt <= cnt + 1'b1;
                        if (mem_rlast) begin
                            state <= P_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // command and line held while the bus stalls
    always_ff @(posedge clk) begin
        if (start && state == P_IDLE) begin
            cmd_q   <= cmd;
            wline_q <= wline;
        end
        if (state == P_RD && mem_rvalid) begin
            rline_q[cnt] <= mem_rdata;
        end
    end

    assign mem_req       = cmd_q;
    assign mem_req_valid = (state == P_CMD);
    assign mem_wvalid    = (state == P_WR);
    assign mem_wdata     = wline_q[cnt];
    assign rline         = rline_q;

    a_rvalid_in_read: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid |-> state == P_RD);

endmodule

// File: src/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        DC_BYTE = 2'd0,
        DC_HALF = 2'd1,
        DC_WORD = 2'd2
    } dc_size_e;

    // flat byte address, or split into lookup fields
    typedef union packed {
        logic [`DC_ADDR_W-1:0] raw;
        struct packed {
            logic [`DC_TAG_W-1:0] tag;
            logic [`DC_IDX_W-1:0] index;
            logic [`DC_OFS_W-3:0] word;
            logic [1:0]           byte_sel;
        } f;
    } dc_addr_u;

    typedef struct packed {
        logic        write;
        dc_size_e    size;
        logic        sign_ext;
        dc_addr_u    addr;
        logic [31:0] wdata;
    } dc_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        misaligned;
    } dc_resp_t;

    typedef struct packed {
        logic                  write;
        logic [`DC_ADDR_W-1:0] line_addr;
    } dc_mem_req_t;

    typedef logic [`DC_LINE_WORDS-1:0][31:0] dc_line_t;

endpackage

// File: src/dcache_tag_array.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_tag_array (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::dc_addr_u lookup_addr,
    input  logic [`DC_IDX_W-1:0] idx,
    input  logic                 we,
    input  logic                 way,
    input  logic                 dirty_set,
    input  logic                 lru_touch,
    output logic                 hit,
    output logic                 hit_way,
    output logic                 victim_way,
    output logic                 victim_dirty,
    output logic [`DC_TAG_W-1:0] victim_tag
);
    logic [`DC_TAG_W-1:0]              tag_mem [`DC_WAYS][`DC_SETS];
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_q;
    logic [`DC_SETS-1:0]               lru_q;
    logic [`DC_TAG_W-1:0]              rd_tag [`DC_WAYS];
    logic [`DC_WAYS-1:0]               rd_valid;
    logic [`DC_WAYS-1:0]               rd_dirty;
    logic [`DC_WAYS-1:0]               match;
    logic                              rd_lru;
    logic                              vic;

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            rd_tag[w] <= tag_mem[w][idx];
        end
        if (we) begin
            tag_mem[way][idx] <= lookup_addr.f.tag;
        end
        victim_tag <= rd_tag[vic];
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = rd_valid[w] && (rd_tag[w] == lookup_addr.f.tag);
        end
        // empty way first, then the lru one
        if (!rd_valid[0]) begin
            vic = 1'b0;
        end else if (!rd_valid[1]) begin
            vic = 1'b1;
        end else begin
            vic = rd_lru;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q      <= '0;
            dirty_q      <= '0;
            lru_q        <= '0;
            rd_valid     <= '0;
            rd_dirty     <= '0;
            rd_lru       <= 1'b0;
            hit          <= 1'b0;
            hit_way      <= 1'b0;
            victim_way   <= 1'b0;
            victim_dirty <= 1'b0;
        end else begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                rd_valid[w] <= valid_q[w][idx];
                rd_dirty[w] <= dirty_q[w][idx];
            end
            rd_lru <= lru_q[idx];
            if (we) begin
                valid_q[way][idx] <= 1'b1;
                dirty_q[way][idx] <= dirty_set;
            end
            if (lru_touch) begin
                lru_q[idx] <= ~way;
            end
            hit          <= |match;
            hit_way      <= match[1];
            victim_way   <= vic;
            victim_dirty <= rd_valid[vic] & rd_dirty[vic];
        end
    end

    // a refill only ever installs into the victim way
    a_single_match: assert property (@(posedge clk) disable iff (rst)
        !(match[0] && match[1]));

endmodule

// File: src/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  dcache_pkg::dc_req_t     req,
    input  logic                    req_valid,
    output logic                    req_ready,
    output dcache_pkg::dc_resp_t    resp,
    output logic                    resp_valid,
    output dcache_pkg::dc_mem_req_t mem_req,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output logic [31:0]             mem_wdata,
    output logic                    mem_wvalid,
    input  logic                    mem_wready,
    input  logic [31:0]             mem_rdata,
    input  logic                    mem_rvalid,
    input  logic                    mem_rlast
);
    import dcache_pkg::*;

    dc_req_t                   req_buf;
    logic                      hit;
    logic                      hit_way;
    logic                      victim_way;
    logic                      victim_dirty;
    logic [`DC_TAG_W-1:0]      victim_tag;
    logic [`DC_IDX_W-1:0]      tag_idx;
    logic                      tag_we;
    logic                      tag_way;
    logic                      tag_dirty_set;
    logic                      lru_touch;
    logic [`DC_IDX_W-1:0]      data_idx;
    logic                      data_we;
    logic                      data_way;
    logic [`DC_LINE_WORDS-1:0] data_wstrb;
    dc_line_t                  data_wline;
    dc_line_t                  line_rdata;
    logic [31:0]               ld_data;
    logic [31:0]               st_word;
    logic                      misaligned;
    logic                      mp_start;
    dc_mem_req_t               mp_cmd;
    dc_line_t                  mp_wline;
    dc_line_t                  mp_rline;
    logic                      mp_done;

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_buf       (req_buf),
        .resp          (resp),
        .resp_valid    (resp_valid),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .tag_idx       (tag_idx),
        .tag_we        (tag_we),
        .tag_way       (tag_way),
        .tag_dirty_set (tag_dirty_set),
        .lru_touch     (lru_touch),
        .data_idx      (data_idx),
        .data_we       (data_we),
        .data_way      (data_way),
        .data_wstrb    (data_wstrb),
        .data_wline    (data_wline),
        .line_rdata    (line_rdata),
        .ld_data       (ld_data),
        .st_word       (st_word),
        .misaligned    (misaligned),
        .mp_start      (mp_start),
        .mp_cmd        (mp_cmd),
        .mp_wline      (mp_wline),
        .mp_rline      (mp_rline),
        .mp_done       (mp_done)
    );

    dcache_tag_array u_tags (
        .clk          (clk),
        .rst          (rst),
        .lookup_addr  (req_buf.addr),
        .idx          (tag_idx),
        .we           (tag_we),
        .way          (tag_way),
        .dirty_set    (tag_dirty_set),
        .lru_touch    (lru_touch),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_data_array u_data (
        .clk    (clk),
        .rd_idx (data_idx),
        .rd_way (data_way),
        .rdata  (line_rdata),
        .wr_idx (data_idx),
        .we     (data_we),
        .wr_way (data_way),
        .wstrb  (data_wstrb),
        .wline  (data_wline)
    );

    dcache_align u_align (
        .req        (req_buf),
        .line       (line_rdata),
        .ld_data    (ld_data),
        .st_word    (st_word),
        .misaligned (misaligned)
    );

    dcache_mem_port u_mem_port (
        .clk           (clk),
        .rst           (rst),
        .start         (mp_start),
        .cmd           (mp_cmd),
        .wline         (mp_wline),
        .rline         (mp_rline),
        .done          (mp_done),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_wdata     (mem_wdata),
        .mem_wvalid    (mem_wvalid),
        .mem_wready    (mem_wready),
        .mem_rdata     (mem_rdata),
        .mem_rvalid    (mem_rvalid),
        .mem_rlast     (mem_rlast)
    );

endmodule

// File: tb/dcache_mem_model.sv
`timescale 1ns/1ns

module dcache_mem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [31:0]             rnd,
    input  logic                    stall_en,
    input  dcache_pkg::dc_mem_req_t mem_req,
    input  logic                    mem_req_valid,
    output logic                    mem_req_ready,
    input  logic [31:0]             mem_wdata,
    input  logic                    mem_wvalid,
    output logic                    mem_wready,
    output logic [31:0]             mem_rdata,
    output logic                    mem_rvalid,
    output logic                    mem_rlast
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        M_IDLE,
        M_WR,
        M_RD
    } mstate_e;

    // 16 KB backing store, word addressed
    logic [31:0] mem [4096];
    int          cmd_count;
    mstate_e     st;
    logic [9:0]  line;
    logic [1:0]  beat;
    logic [1:0]  lat;
    logic        stall;

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 32'h1357_9bdf ^ (32'(i) * 32'h9e37_79b9);
        end
    end

    assign stall         = stall_en && (rnd[5:4] == 2'b00);
    assign mem_req_ready = (st == M_IDLE) && !stall;
    assign mem_wready    = (st == M_WR) && !stall;
    assign mem_rvalid    = (st == M_RD) && (lat == 2'd0) && !stall;
    assign mem_rlast     = mem_rvalid && (beat == 2'd3);
    assign mem_rdata     = mem[{line, beat}];

    always @(posedge clk) begin
        if (rst) begin
            st        <= M_IDLE;
            cmd_count <= 0;
            beat      <= '0;
            lat       <= '0;
        end else begin
            case (st)
                M_IDLE: begin
                    if (mem_req_valid && mem_req_ready) begin
                        cmd_count <= cmd_count + 1;
                        line      <= mem_req.line_addr[13:4];
                        beat      <= '0;
                        lat       <= 2'd2;
                        st        <= mem_req.write ? M_WR : M_RD;
                    end
                end
                M_WR: begin
                    if (mem_wvalid && mem_wready) begin
                        mem[{line, beat}] <= mem_wdata;
                        beat <= beat + 2'd1;
                        if (beat == 2'd3) begin
                            st <= M_IDLE;
                        end
                    end
                end
                default: begin
                    if (lat != 2'd0) begin
                        lat <= lat - 2'd1;
                    end else if (mem_rvalid) begin
                        beat <= beat + 2'd1;
                        if (beat == 2'd3) begin
                            st <= M_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: tb/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;

    localparam logic [31:0] SEED = 32'h0357_40fc;

    logic          clk;
    logic          rst;
    dc_req_t       req;
    logic          req_valid;
    logic          req_ready;
    dc_resp_t      resp;
    logic          resp_valid;
    dc_mem_req_t   mem_req;
    logic          mem_req_valid;
    logic          mem_req_ready;
    logic [31:0]   mem_wdata;
    logic          mem_wvalid;
    logic          mem_wready;
    logic [31:0]   mem_rdata;
    logic          mem_rvalid;
    logic          mem_rlast;
    logic [31:0]   mem_rnd;
    logic          stall_en;
    logic [31:0]   seed;
    logic [31:0]   shadow [4096];
    logic [34:0]   exp_q[$];
    string         name_q[$];
    int            errors;
    int            checks;
    int            issued;
    int            resp_count;
    int            cycles;
    int            acc_cyc;

    dcache_top u_dut (
        .clk(clk), .rst(rst),
        .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .resp(resp), .resp_valid(resp_valid),
        .mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_wdata(mem_wdata), .mem_wvalid(mem_wvalid), .mem_wready(mem_wready),
        .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid), .mem_rlast(mem_rlast)
    );

    dcache_mem_model u_mem (
        .clk(clk), .rst(rst), .rnd(mem_rnd), .stall_en(stall_en),
        .mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_wdata(mem_wdata), .mem_wvalid(mem_wvalid), .mem_wready(mem_wready),
        .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid), .mem_rlast(mem_rlast)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic dc_req_t make_req(input logic wr, input dc_size_e sz, input logic sx,
                                         input logic [31:0] addr, input logic [31:0] wdata);
        dc_req_t r;
        r.write    = wr;
        r.size     = sz;
        r.sign_ext = sx;
        r.addr.raw = addr;
        r.wdata    = wdata;
        return r;
    endfunction

    // expected {misaligned, load value}; stores update the shadow copy
    function automatic logic [32:0] ref_access(input dc_req_t r);
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] val;
        int          nb;
        a   = r.addr.raw;
        nb  = (r.size == DC_BYTE) ? 1 : (r.size == DC_HALF) ? 2 : 4;
        val = '0;
        if ((a % nb) != 0) begin
            return {1'b1, 32'h0};
        end
        w = shadow[a[13:2]];
        for (int k = 0; k < nb; k++) begin
            if (r.write) begin
                w[8 * (a[1:0] + k) +: 8] = r.wdata[8 * k +: 8];
            end else begin
                val[8 * k +: 8] = w[8 * (a[1:0] + k) +: 8];
            end
        end
        shadow[a[13:2]] = w;
        if (!r.write && r.sign_ext && nb < 4 && val[8 * nb - 1]) begin
            val = val | (32'hffff_ffff << (8 * nb));
        end
        return {1'b0, val};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic send_req(input dc_req_t r, input string name, input logic lat_chk);
        logic [32:0] e;
        @(posedge clk);
        e = ref_access(r);
        exp_q.push_back({lat_chk, !r.write, e});
        name_q.push_back(name);
        issued++;
        req       <= r;
        req_valid <= 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        while (resp_count < issued) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        mem_rnd <= lcg_next(mem_rnd);
    end

    // response compare
    always @(posedge clk) begin
        logic [34:0] e;
        string       nm;
        cycles <= cycles + 1;
        if (req_valid && req_ready) begin
            acc_cyc <= cycles;
        end
        if (!rst && resp_valid) begin
            resp_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("response seen with no outstanding request");
            end else begin
                e  = exp_q.pop_front();
                nm = name_q.pop_front();
                check_value({nm, " misaligned"}, 32'(e[32]), 32'(resp.misaligned));
                if (!e[32] && e[33]) begin
                    check_value({nm, " rdata"}, e[31:0], resp.rdata);
                end
                if (e[34]) begin
                    check_value({nm, " latency"}, 32'd3, 32'(cycles - acc_cyc));
                end
            end
        end
        if (!rst && cycles > 400 * (issued + 1)) begin
            $display("timeout: no response within %0d cycles, %0d requests issued",
                     cycles, issued);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int          cmds;
        logic [31:0] a;
        dc_size_e    sz;
        rst        = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        stall_en   = 1'b0;
        mem_rnd    = SEED;
        seed       = lcg_next(SEED);
        errors     = 0;
        checks     = 0;
        issued     = 0;
        resp_count = 0;
        cycles     = 0;
        acc_cyc    = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = u_mem.mem[i];
        end

        // idle outputs after reset
        repeat (4) begin
            @(negedge clk);
            check_value("reset req_ready", 32'd1, 32'(req_ready));
            check_value("reset resp_valid", 32'd0, 32'(resp_valid));
            check_value("reset mem_req_valid", 32'd0, 32'(mem_req_valid));
            check_value("reset mem_wvalid", 32'd0, 32'(mem_wvalid));
        end

        // every size, signed and unsigned
        send_req(make_req(1, DC_WORD, 0, 32'h200, 32'h80f1_7f02), "st_word", 0);
        for (int b = 0; b < 4; b++) begin
            send_req(make_req(0, DC_BYTE, 1, 32'h200 + b, 0), "ld_byte_s", 0);
            send_req(make_req(0, DC_BYTE, 0, 32'h200 + b, 0), "ld_byte_u", 0);
        end
        send_req(make_req(0, DC_HALF, 1, 32'h200, 0), "ld_half_s", 0);
        send_req(make_req(0, DC_HALF, 0, 32'h202, 0), "ld_half_u", 0);
        send_req(make_req(0, DC_HALF, 1, 32'h202, 0), "ld_half_s", 0);
        send_req(make_req(1, DC_BYTE, 0, 32'h201, 32'hffff_ffa5), "st_byte", 0);
        send_req(make_req(1, DC_HALF, 0, 32'h206, 32'h0000_9234), "st_half", 0);
        send_req(make_req(0, DC_WORD, 0, 32'h200, 0), "ld_merged", 0);
        send_req(make_req(0, DC_WORD, 0, 32'h204, 0), "ld_merged", 0);

        // hit on a freshly filled line
        send_req(make_req(0, DC_WORD, 0, 32'h3040, 0), "fill_miss", 0);
        send_req(make_req(0, DC_WORD, 0, 32'h3044, 0), "hit_timing", 1);
        send_req(make_req(1, DC_BYTE, 0, 32'h3048, 32'h11), "hit_timing", 1);

        // three lines in one set
        send_req(make_req(1, DC_WORD, 0, 32'h0100, 32'haaaa_0001), "evict_st", 0);
        send_req(make_req(1, DC_WORD, 0, 32'h0504, 32'hbbbb_0002), "evict_st", 0);
        send_req(make_req(1, DC_WORD, 0, 32'h0908, 32'hcccc_0003), "evict_st", 0);
        for (int i = 64; i < 68; i++) begin
            check_value("evict_wb", shadow[i], u_mem.mem[i]);
        end
        send_req(make_req(0, DC_WORD, 0, 32'h0100, 0), "evict_ld", 0);
        for (int i = 320; i < 324; i++) begin
            check_value("evict_wb", shadow[i], u_mem.mem[i]);
        end
        send_req(make_req(0, DC_WORD, 0, 32'h0504, 0), "evict_ld", 0);
        send_req(make_req(0, DC_WORD, 0, 32'h0908, 0), "evict_ld", 0);

        // misaligned requests
        cmds = u_mem.cmd_count;
        send_req(make_req(0, DC_HALF, 0, 32'h2201, 0), "mis_half", 1);
        send_req(make_req(0, DC_WORD, 0, 32'h2202, 0), "mis_word", 1);
        send_req(make_req(1, DC_WORD, 0, 32'h2203, 32'hdead_beef), "mis_store", 1);
        check_value("mis_no_mem_cmd", 32'(cmds), 32'(u_mem.cmd_count));
        send_req(make_req(0, DC_WORD, 0, 32'h2200, 0), "mis_after", 0);
        // line now cached, a misaligned store must not touch it
        send_req(make_req(1, DC_WORD, 0, 32'h2201, 32'h5a5a_a5a5), "mis_store_hit", 1);
        send_req(make_req(0, DC_WORD, 0, 32'h2200, 0), "mis_after", 0);

        // random mix with memory stalls
        stall_en <= 1'b1;
        for (int n = 0; n < 300; n++) begin
            seed = lcg_next(seed);
            a    = {18'h0, seed[13:0]};
            case (seed[17:16])
                2'd0:    sz = DC_BYTE;
                2'd1:    sz = DC_HALF;
                default: sz = DC_WORD;
            endcase
            if (seed[20]) begin
                a[1:0] = 2'b00;
            end
            seed = lcg_next(seed);
            send_req(make_req(seed[31], sz, seed[30], a, lcg_next(seed)), "random", 0);
        end

        repeat (4) @(posedge clk);
        $display("checks: %0d  errors: %0d  requests: %0d", checks, errors, issued);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_align.sv
src/dcache_mem_port.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv
